/* hw/cpu_pkg.sv */
package cpu_pkg;

    localparam int NB_DATA   = 32;
    localparam int NB_REG    = 5;
    localparam int NB_OPCODE = 6;

    typedef logic [NB_DATA-1:0] word_t;
    typedef logic [NB_REG-1:0]  reg_addr_t;
    typedef logic [NB_DATA-1:0] pc_t;      // Byte address
    typedef logic [3:0]         alu_op_t;

    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_AND = 4'd2;
    localparam alu_op_t ALU_OR  = 4'd3;
    localparam alu_op_t ALU_XOR = 4'd4;
    localparam alu_op_t ALU_SLT = 4'd5;

    localparam logic [NB_OPCODE-1:0] OP_RTYPE = 6'd0;
    localparam logic [NB_OPCODE-1:0] OP_ADDI  = 6'd8;
    localparam logic [NB_OPCODE-1:0] OP_HALT  = 6'h3f;

    localparam logic [NB_OPCODE-1:0] FN_ADD = 6'd32;
    localparam logic [NB_OPCODE-1:0] FN_SUB = 6'd34;
    localparam logic [NB_OPCODE-1:0] FN_AND = 6'd36;
    localparam logic [NB_OPCODE-1:0] FN_OR  = 6'd37;
    localparam logic [NB_OPCODE-1:0] FN_XOR = 6'd38;
    localparam logic [NB_OPCODE-1:0] FN_SLT = 6'd42;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN,
        ST_HALT
    } run_state_t;

endpackage

/* hw/ex_bus_if.sv */
`timescale 1ns/1ns

interface ex_bus_if;
    import cpu_pkg::*;

    logic      valid;
    alu_op_t   alu_op;
    word_t     operand_a;
    word_t     operand_b;
    logic      b_is_imm;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dest;
    logic      reg_write;

    modport decode (output valid, alu_op, operand_a, operand_b, b_is_imm, rs, rt, dest, reg_write);
    modport execute (input valid, alu_op, operand_a, operand_b, b_is_imm, rs, rt, dest, reg_write);

endinterface

/* hw/run_control.sv */
`timescale 1ns/1ns

module run_control (
    input  logic i_clock,
    input  logic i_arst_n,
    input  logic i_start,
    input  logic i_halt_seen,
    input  logic i_im_write_enable,
    output logic o_run_start,
    output logic o_fetch_en,
    output logic o_im_we,
    output logic o_hlt
);
    import cpu_pkg::*;

    run_state_t state;
    logic       drain_cnt;
    logic       stopped;

    assign stopped     = (state == ST_IDLE) || (state == ST_HALT);
    assign o_run_start = i_start && stopped;
    assign o_fetch_en  = (state == ST_RUN) && !i_halt_seen;  // Stop on the HALT cycle itself
    assign o_im_we     = i_im_write_enable && stopped;
    assign o_hlt       = (state == ST_HALT);

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state     <= ST_IDLE;
            drain_cnt <= 1'b0;
        end else begin
            case (state)
                ST_IDLE, ST_HALT: begin
                    if (o_run_start) state <= ST_RUN;
                end
                ST_RUN: begin
                    if (i_halt_seen) begin
                        state     <= ST_DRAIN;
                        drain_cnt <= 1'b0;
                    end
                end
                ST_DRAIN: begin
                    drain_cnt <= 1'b1;
                    if (drain_cnt) state <= ST_HALT;  // Last write lands on the first drain edge
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* hw/program_counter.sv */
`timescale 1ns/1ns

module program_counter #(
    parameter int IM_ADDR_W = 6
) (
    input  logic                 i_clock,
    input  logic                 i_arst_n,
    input  logic                 i_clear,
    input  logic                 i_enable,
    output cpu_pkg::pc_t         o_pc,
    output logic [IM_ADDR_W-1:0] o_im_index
);
    logic [IM_ADDR_W-1:0] next_index;

    assign o_im_index = o_pc[IM_ADDR_W+1:2];
    assign next_index = o_im_index + 1'b1;  // Wraps inside the memory

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc <= '0;
        end else if (i_clear) begin
            o_pc <= '0;
        end else if (i_enable) begin
            o_pc <= cpu_pkg::pc_t'({next_index, 2'b00});
        end
    end

endmodule

/* hw/instr_mem.sv */
`timescale 1ns/1ns

module instr_mem #(
    parameter int IM_ADDR_W = 6
) (
    input  logic                 i_clock,
    input  logic                 i_arst_n,
    input  logic                 i_we,
    input  logic [IM_ADDR_W-1:0] i_waddr,
    input  cpu_pkg::word_t       i_wdata,
    input  logic                 i_read_en,
    input  logic [IM_ADDR_W-1:0] i_raddr,
    output cpu_pkg::word_t       o_instr,
    output logic                 o_valid
);
    cpu_pkg::word_t mem [2**IM_ADDR_W];

    always_ff @(posedge i_clock) begin
        if (i_we) mem[i_waddr] <= i_wdata;
        if (i_read_en) o_instr <= mem[i_raddr];  // IF/ID instruction
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) o_valid <= 1'b0;
        else           o_valid <= i_read_en;
    end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
    input  logic               i_clock,
    input  logic               i_arst_n,
    input  cpu_pkg::reg_addr_t i_rs,
    input  cpu_pkg::reg_addr_t i_rt,
    input  cpu_pkg::reg_addr_t i_dbg_addr,
    input  logic               i_we,
    input  cpu_pkg::reg_addr_t i_waddr,
    input  cpu_pkg::word_t     i_wdata,
    output cpu_pkg::word_t     o_rs_data,
    output cpu_pkg::word_t     o_rt_data,
    output cpu_pkg::word_t     o_dbg_data
);
    import cpu_pkg::*;

    word_t regs [32];

    // Same-cycle write is visible to the reader
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0)                    return '0;
        else if (i_we && i_waddr == addr) return i_wdata;
        else                              return regs[addr];
    endfunction

    always_comb begin
        o_rs_data  = read_port(i_rs);
        o_rt_data  = read_port(i_rt);
        o_dbg_data = read_port(i_dbg_addr);
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic               i_clock,
    input  logic               i_arst_n,
    input  cpu_pkg::word_t     i_instr,
    input  logic               i_valid,
    input  cpu_pkg::word_t     i_rs_data,
    input  cpu_pkg::word_t     i_rt_data,
    output cpu_pkg::reg_addr_t o_rs,
    output cpu_pkg::reg_addr_t o_rt,
    output logic               o_halt_seen,
    ex_bus_if.decode           o_ex
);
    import cpu_pkg::*;

    logic [NB_OPCODE-1:0] opcode;
    logic [NB_OPCODE-1:0] funct;
    reg_addr_t            rd;
    word_t                imm_ext;
    alu_op_t              alu_op;
    logic                 legal;
    logic                 use_imm;
    reg_addr_t            dest;

    assign opcode      = i_instr[31:26];
    assign o_rs        = i_instr[25:21];
    assign o_rt        = i_instr[20:16];
    assign rd          = i_instr[15:11];
    assign funct       = i_instr[5:0];
    assign imm_ext     = {{(NB_DATA-16){i_instr[15]}}, i_instr[15:0]};
    assign o_halt_seen = i_valid && (opcode == OP_HALT);

    always_comb begin
        alu_op  = ALU_ADD;
        legal   = 1'b1;
        use_imm = 1'b0;
        dest    = rd;
        case (opcode)
            OP_RTYPE: begin
                case (funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: legal  = 1'b0;
                endcase
            end
            OP_ADDI: begin
                use_imm = 1'b1;
                dest    = o_rt;
            end
            default: legal = 1'b0;  // HALT and unknown opcodes become bubbles
        endcase
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) o_ex.valid <= 1'b0;
        else           o_ex.valid <= i_valid && legal;
    end

    always_ff @(posedge i_clock) begin
        o_ex.alu_op    <= alu_op;
        o_ex.operand_a <= i_rs_data;
        o_ex.operand_b <= use_imm ? imm_ext : i_rt_data;
        o_ex.b_is_imm  <= use_imm;
        o_ex.rs        <= o_rs;
        o_ex.rt        <= o_rt;
        o_ex.dest      <= dest;
        o_ex.reg_write <= (dest != '0);  // r0 is never written
    end

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
    input  logic               i_clock,
    input  logic               i_arst_n,
    input  logic               i_clear_oe,
    ex_bus_if.execute          i_ex,
    output logic               o_wb_we,
    output cpu_pkg::reg_addr_t o_wb_addr,
    output cpu_pkg::word_t     o_wb_data,
    output logic               o_oe
);
    import cpu_pkg::*;

    localparam int MSB = NB_DATA - 1;

    logic  fwd_a;
    logic  fwd_b;
    word_t op_a;
    word_t op_b;
    word_t sum;
    word_t diff;
    word_t result;
    logic  ovf;

    // Previous slot result still sits in EX/WB
    assign fwd_a = o_wb_we && (o_wb_addr == i_ex.rs) && (i_ex.rs != '0);
    assign fwd_b = o_wb_we && (o_wb_addr == i_ex.rt) && (i_ex.rt != '0) && !i_ex.b_is_imm;
    assign op_a  = fwd_a ? o_wb_data : i_ex.operand_a;
    assign op_b  = fwd_b ? o_wb_data : i_ex.operand_b;
    assign sum   = op_a + op_b;
    assign diff  = op_a - op_b;

    always_comb begin
        result = sum;
        ovf    = 1'b0;
        case (i_ex.alu_op)
            ALU_ADD: ovf = (op_a[MSB] == op_b[MSB]) && (sum[MSB] != op_a[MSB]);
            ALU_SUB: begin
                result = diff;
                ovf    = (op_a[MSB] != op_b[MSB]) && (diff[MSB] != op_a[MSB]);
            end
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SLT: result = word_t'($signed(op_a) < $signed(op_b));
            default: result = sum;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb_we <= 1'b0;
            o_oe    <= 1'b0;
        end else begin
            o_wb_we <= i_ex.valid && i_ex.reg_write && !ovf;
            if (i_clear_oe)            o_oe <= 1'b0;
            else if (i_ex.valid && ovf) o_oe <= 1'b1;  // Sticky until next start
        end
    end

    always_ff @(posedge i_clock) begin
        o_wb_addr <= i_ex.dest;
        o_wb_data <= result;
    end

endmodule

/* hw/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top #(
    parameter int IM_ADDR_W = 6
) (
    input  logic                 i_clock,
    input  logic                 i_arst_n,
    input  logic                 i_start,
    input  logic                 i_im_write_enable,
    input  logic [IM_ADDR_W-1:0] i_im_address,
    input  cpu_pkg::word_t       i_im_data,
    input  cpu_pkg::reg_addr_t   i_rb_address,
    output cpu_pkg::word_t       o_rb_data,
    output cpu_pkg::pc_t         o_pc_value,
    output logic                 o_hlt,
    output logic                 o_oe
);
    import cpu_pkg::*;

    logic                 run_start;
    logic                 fetch_en;
    logic                 im_we;
    logic                 halt_seen;
    logic [IM_ADDR_W-1:0] im_index;
    word_t                id_instr;
    logic                 id_valid;
    reg_addr_t            id_rs;
    reg_addr_t            id_rt;
    word_t                rs_data;
    word_t                rt_data;
    logic                 wb_we;
    reg_addr_t            wb_addr;
    word_t                wb_data;

    ex_bus_if ex_bus ();

    run_control u_run_control (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_start(i_start),
        .i_halt_seen(halt_seen), .i_im_write_enable(i_im_write_enable),
        .o_run_start(run_start), .o_fetch_en(fetch_en), .o_im_we(im_we), .o_hlt(o_hlt));

    program_counter #(.IM_ADDR_W(IM_ADDR_W)) u_pc (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_clear(run_start), .i_enable(fetch_en),
        .o_pc(o_pc_value), .o_im_index(im_index));

    instr_mem #(.IM_ADDR_W(IM_ADDR_W)) u_instr_mem (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_we(im_we), .i_waddr(i_im_address),
        .i_wdata(i_im_data), .i_read_en(fetch_en), .i_raddr(im_index),
        .o_instr(id_instr), .o_valid(id_valid));

    reg_file u_reg_file (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_rs(id_rs), .i_rt(id_rt),
        .i_dbg_addr(i_rb_address), .i_we(wb_we), .i_waddr(wb_addr), .i_wdata(wb_data),
        .o_rs_data(rs_data), .o_rt_data(rt_data), .o_dbg_data(o_rb_data));

    decode_stage u_decode (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_instr(id_instr), .i_valid(id_valid),
        .i_rs_data(rs_data), .i_rt_data(rt_data), .o_rs(id_rs), .o_rt(id_rt),
        .o_halt_seen(halt_seen), .o_ex(ex_bus.decode));

    execute_stage u_execute (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_clear_oe(run_start), .i_ex(ex_bus.execute),
        .o_wb_we(wb_we), .o_wb_addr(wb_addr), .o_wb_data(wb_data), .o_oe(o_oe));

endmodule

/* test/cpu_asserts.sv */
`timescale 1ns/1ns

module cpu_asserts (
    input  logic               i_clock,
    input  logic               i_arst_n,
    input  logic               i_hlt,
    input  cpu_pkg::pc_t       i_pc,
    input  logic               i_wb_we,
    input  cpu_pkg::reg_addr_t i_wb_addr,
    input  logic               i_run_start,
    input  logic               i_oe
);

    pc_hold: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_hlt && $past(i_hlt) |-> $stable(i_pc))
        else $error("PC moved while halted");

    no_r0_write: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        !(i_wb_we && i_wb_addr == '0))
        else $error("Write-back enabled for r0");

    // Only a start clears the flag
    oe_sticky: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        $fell(i_oe) |-> $past(i_run_start))
        else $error("Overflow flag dropped without a start");

endmodule

bind cpu_top cpu_asserts u_asserts (
    .i_clock(i_clock), .i_arst_n(i_arst_n), .i_hlt(o_hlt), .i_pc(o_pc_value),
    .i_wb_we(wb_we), .i_wb_addr(wb_addr), .i_run_start(run_start), .i_oe(o_oe));

/* test/tb_cpu.sv */
`timescale 1ns/1ns

module tb_cpu;
    import cpu_pkg::*;

    localparam int    IM_ADDR_W  = 6;
    localparam int    MAX_LEN    = 2**IM_ADDR_W;
    localparam int    NUM_RUNS   = 9;
    localparam int    TIMEOUT_NS = NUM_RUNS * (MAX_LEN + 20) * 10 * 2;
    localparam word_t HALT_WORD  = {OP_HALT, 26'd0};

    logic                 clock;
    logic                 arst_n;
    logic                 start;
    logic                 im_we;
    logic [IM_ADDR_W-1:0] im_addr;
    word_t                im_data;
    reg_addr_t            rb_addr;
    word_t                rb_data;
    pc_t                  pc_value;
    logic                 hlt;
    logic                 oe;

    word_t prog [MAX_LEN];
    int    prog_len;
    word_t exp_regs [32];
    logic  exp_oe;
    word_t lcg_state = 32'd77;
    int    n_checks  = 0;
    int    n_errors  = 0;
    pc_t   pc_at_halt;

    cpu_top #(.IM_ADDR_W(IM_ADDR_W)) DUT (
        .i_clock(clock), .i_arst_n(arst_n), .i_start(start),
        .i_im_write_enable(im_we), .i_im_address(im_addr), .i_im_data(im_data),
        .i_rb_address(rb_addr), .o_rb_data(rb_data), .o_pc_value(pc_value),
        .o_hlt(hlt), .o_oe(oe));

    always #5 clock = ~clock;

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];  // Upper bits have the longer period
    endfunction

    function automatic word_t enc_r(input int rs, input int rt, input int rd,
                                    input logic [5:0] fn);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word_t enc_addi(input int rs, input int rt, input logic [15:0] imm);
        return {OP_ADDI, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic void append_instr(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endfunction

    // Sequential model of the program from the current register state
    function automatic void ref_run();
        word_t      a;
        word_t      b;
        word_t      res;
        longint     wide;
        logic [5:0] op;
        logic       wr;
        logic       ovf;
        int         dst;
        exp_oe = 1'b0;
        for (int pc = 0; pc < prog_len; pc++) begin
            op = prog[pc][31:26];
            if (op == OP_HALT) break;
            a    = exp_regs[prog[pc][25:21]];
            b    = exp_regs[prog[pc][20:16]];
            dst  = int'(prog[pc][15:11]);
            wr   = 1'b1;
            ovf  = 1'b0;
            res  = '0;
            wide = 0;
            if (op == OP_ADDI) begin
                b    = {{16{prog[pc][15]}}, prog[pc][15:0]};
                dst  = int'(prog[pc][20:16]);
                res  = a + b;
                wide = longint'($signed(a)) + longint'($signed(b));
                ovf  = (wide != longint'($signed(res)));
            end else if (op == OP_RTYPE) begin
                case (prog[pc][5:0])
                    FN_ADD: begin
                        res  = a + b;
                        wide = longint'($signed(a)) + longint'($signed(b));
                        ovf  = (wide != longint'($signed(res)));
                    end
                    FN_SUB: begin
                        res  = a - b;
                        wide = longint'($signed(a)) - longint'($signed(b));
                        ovf  = (wide != longint'($signed(res)));
                    end
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end else begin
                wr = 1'b0;
            end
            if (ovf) exp_oe = 1'b1;
            else if (wr && dst != 0) exp_regs[dst] = res;
        end
    endfunction

    // ADDI seeds for r1..r7, then a chain where each op reads the last result
    task automatic make_random_program(input int n_chain);
        int         last;
        int         rd;
        logic [5:0] fn;
        prog_len = 0;
        for (int r = 1; r < 8; r++) append_instr(enc_addi(0, r, next_rand()));
        last = 7;
        for (int k = 0; k < n_chain; k++) begin
            case (next_rand() % 6)
                0:       fn = FN_ADD;
                1:       fn = FN_SUB;
                2:       fn = FN_AND;
                3:       fn = FN_OR;
                4:       fn = FN_XOR;
                default: fn = FN_SLT;
            endcase
            rd = int'(next_rand() % 8);  // r0 now and then
            append_instr(enc_r(last, 1 + int'(next_rand() % 7), rd, fn));
            if (rd != 0) last = rd;
        end
        append_instr(HALT_WORD);
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(negedge clock);
            im_we   = 1'b1;
            im_addr = IM_ADDR_W'(i);
            im_data = prog[i];
        end
        @(negedge clock);
        im_we = 1'b0;
    endtask

    task automatic run_program(input bit write_during_run);
        @(negedge clock);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        if (write_during_run) begin
            im_we   = 1'b1;
            im_addr = '0;
            im_data = enc_addi(0, 1, 16'h1234);
            @(negedge clock);
            im_we = 1'b0;
        end
        while (!hlt) @(negedge clock);
    endtask

    task automatic compare(input string name, input word_t expected, input word_t actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_state(input string name);
        ref_run();
        for (int r = 0; r < 32; r++) begin
            @(negedge clock);
            rb_addr = reg_addr_t'(r);
            #1;
            compare($sformatf("%s r%0d", name, r), exp_regs[r], rb_data);
        end
        compare({name, " o_oe"}, word_t'(exp_oe), word_t'(oe));
    endtask

    initial begin
        clock   = 1'b0;
        arst_n  = 1'b0;
        start   = 1'b0;
        im_we   = 1'b0;
        im_addr = '0;
        im_data = '0;
        rb_addr = '0;
        for (int r = 0; r < 32; r++) exp_regs[r] = '0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        compare("reset o_hlt", '0, word_t'(hlt));
        compare("reset o_oe", '0, word_t'(oe));
        compare("reset o_pc_value", '0, pc_value);

        for (int t = 0; t < 4; t++) begin
            make_random_program(12 + t * 4);
            load_program();
            run_program(1'b0);
            check_state($sformatf("random_%0d", t));
        end

        prog_len = 0;
        append_instr(enc_addi(0, 1, 16'h4000));
        for (int k = 0; k < 16; k++) append_instr(enc_r(1, 1, 1, FN_ADD));  // r1 up to 2^30
        append_instr(enc_addi(1, 3, 16'hffff));
        append_instr(enc_r(1, 3, 4, FN_ADD));  // Largest positive word
        append_instr(enc_addi(4, 4, 16'h0001));
        append_instr(enc_r(1, 1, 2, FN_ADD));
        append_instr(HALT_WORD);
        load_program();
        run_program(1'b0);
        check_state("overflow");

        prog_len = 0;
        append_instr(enc_addi(0, 0, 16'h0055));
        append_instr(enc_addi(0, 5, 16'h0003));
        append_instr(enc_r(5, 5, 0, FN_ADD));
        append_instr(enc_r(0, 5, 6, FN_OR));  // r0 read right after a write attempt
        append_instr(HALT_WORD);
        load_program();
        run_program(1'b0);
        check_state("reg_zero");

        prog_len = 0;
        append_instr(enc_addi(0, 7, 16'h0011));
        append_instr(HALT_WORD);
        append_instr(enc_addi(0, 7, 16'h0099));
        append_instr(enc_r(7, 7, 8, FN_ADD));
        load_program();
        run_program(1'b0);
        pc_at_halt = pc_t'(2 * 4);  // Fetch stops after the HALT word at index 1
        compare("pc at halt", pc_at_halt, pc_value);
        check_state("after_halt");
        compare("pc hold", pc_at_halt, pc_value);

        make_random_program(16);
        load_program();
        run_program(1'b1);
        check_state("write_in_run");
        run_program(1'b0);
        check_state("rerun");

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the core did not halt within %0d ns", TIMEOUT_NS);
        $display("Errors found");
        $finish;
    end

endmodule

/* sources.f */
hw/cpu_pkg.sv
hw/ex_bus_if.sv
hw/run_control.sv
hw/program_counter.sv
hw/instr_mem.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/cpu_top.sv
test/cpu_asserts.sv
test/tb_cpu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_cpu -f sources.f -o Vtb_cpu
./obj_dir/Vtb_cpu | tee sim.log
if grep -qx "No errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
